//--- src/icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

    // address and instruction widths
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;
    localparam int PAIR_W = 2 * INST_W;

    // two ways, the victim logic depends on it
    localparam int WAY_NUM = 2;

    // one line is 32 bytes, eight words or four pairs
    localparam int LINE_WORDS = 8;
    localparam int LINE_PAIRS = LINE_WORDS / 2;
    localparam int OFFSET_W = 5;

    // burst length field of the memory bus
    localparam int BUS_LEN_W = 4;

endpackage

`default_nettype wire

//--- src/icache_op_pkg.sv
`default_nettype none

package icache_op_pkg;

    localparam int OP_W = 2;

    // cacop codes, 0 and 1 both invalidate by index and way
    localparam logic [OP_W-1:0] CACOP_IDX_INIT = 2'd0;
    localparam logic [OP_W-1:0] CACOP_IDX_INV = 2'd1;
    localparam logic [OP_W-1:0] CACOP_HIT_INV = 2'd2;

    // one cacop address word, read through the view the op code selects
    typedef union packed {
        struct packed {
            logic [icache_cfg_pkg::ADDR_W-2:0] upper;
            logic way_sel;
        } index_view;
        struct packed {
            logic [icache_cfg_pkg::ADDR_W-icache_cfg_pkg::OFFSET_W-1:0] line_addr;
            logic [icache_cfg_pkg::OFFSET_W-1:0] offset;
        } hit_view;
    } cacop_addr_u;

endpackage

`default_nettype wire

//--- src/icache_way.sv
`timescale 1ns/10ps
`default_nettype none

module icache_way #(
    parameter int SET_NUM = 64,
    localparam int IDX_W = $clog2(SET_NUM),
    localparam int TAG_W = icache_cfg_pkg::ADDR_W - icache_cfg_pkg::OFFSET_W - IDX_W,
    localparam int PAIR_IDX_W = $clog2(icache_cfg_pkg::LINE_PAIRS)
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              rd_en_i,
    input  wire logic [IDX_W-1:0]                  rd_index_i,
    input  wire logic [PAIR_IDX_W-1:0]             rd_pair_i,
    input  wire logic [TAG_W-1:0]                  lookup_tag_i,
    input  wire logic                              tag_we_i,
    input  wire logic                              wr_valid_i,
    input  wire logic                              data_we_i,
    input  wire logic [IDX_W-1:0]                  wr_index_i,
    input  wire logic [PAIR_IDX_W-1:0]             wr_pair_i,
    input  wire logic [TAG_W-1:0]                  wr_tag_i,
    input  wire logic [icache_cfg_pkg::PAIR_W-1:0] wr_data_i,
    output logic                                   hit_o,
    output logic [icache_cfg_pkg::PAIR_W-1:0]      pair_o
);

    logic [TAG_W-1:0] tag_mem [SET_NUM];
    logic [SET_NUM-1:0] valid_bits;
    logic [icache_cfg_pkg::PAIR_W-1:0] data_mem [SET_NUM * icache_cfg_pkg::LINE_PAIRS];

    logic [TAG_W-1:0] tag_q;
    logic [TAG_W-1:0] lookup_q;
    logic valid_q;

    // same-cycle write to the read set wins over the array content
    wire tag_fwd = tag_we_i && (wr_index_i == rd_index_i);
    wire data_fwd = data_we_i && (wr_index_i == rd_index_i) && (wr_pair_i == rd_pair_i);

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_mem[wr_index_i] <= wr_tag_i;
        end
        if (data_we_i) begin
            data_mem[{wr_index_i, wr_pair_i}] <= wr_data_i;
        end
        if (rd_en_i) begin
            tag_q <= tag_fwd ? wr_tag_i : tag_mem[rd_index_i];
            lookup_q <= lookup_tag_i;
            pair_o <= data_fwd ? wr_data_i : data_mem[{rd_index_i, rd_pair_i}];
        end
    end

    // valid bits are the only state that needs clearing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
            valid_q <= 1'b0;
        end else begin
            if (tag_we_i) begin
                valid_bits[wr_index_i] <= wr_valid_i;
            end
            if (rd_en_i) begin
                valid_q <= tag_fwd ? wr_valid_i : valid_bits[rd_index_i];
            end
        end
    end

    assign hit_o = valid_q && (tag_q == lookup_q);

endmodule

`default_nettype wire

//--- src/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
    parameter int SET_NUM = 64,
    localparam int IDX_W = $clog2(SET_NUM),
    localparam int TAG_W = icache_cfg_pkg::ADDR_W - icache_cfg_pkg::OFFSET_W - IDX_W,
    localparam int PAIR_IDX_W = $clog2(icache_cfg_pkg::LINE_PAIRS),
    localparam int ADDR_W = icache_cfg_pkg::ADDR_W,
    localparam int WAY_NUM = icache_cfg_pkg::WAY_NUM
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 flush_i,
    input  wire logic                                 fetch_valid_i,
    input  wire logic [ADDR_W-1:0]                    fetch_pc_i,
    input  wire logic                                 cacop_valid_i,
    input  wire logic [icache_op_pkg::OP_W-1:0]       cacop_op_i,
    input  wire logic [ADDR_W-1:0]                    cacop_addr_i,
    input  wire logic                                 mem_ack_i,
    input  wire logic                                 mem_data_valid_i,
    input  wire logic [icache_cfg_pkg::INST_W-1:0]    mem_data_i,
    input  wire logic                                 miss_i,
    input  wire logic [ADDR_W-1:0]                    miss_pc_i,
    input  wire logic [WAY_NUM-1:0]                   way_hit_i,
    output logic                                      fetch_ready_o,
    output logic                                      cacop_ready_o,
    output logic                                      cacop_done_o,
    output logic                                      mem_req_o,
    output logic [ADDR_W-1:0]                         mem_addr_o,
    output logic [icache_cfg_pkg::BUS_LEN_W-1:0]      mem_len_o,
    output logic                                      rd_en_o,
    output logic [IDX_W-1:0]                          rd_index_o,
    output logic [PAIR_IDX_W-1:0]                     rd_pair_o,
    output logic [TAG_W-1:0]                          lookup_tag_o,
    output logic [WAY_NUM-1:0]                        tag_we_o,
    output logic                                      wr_valid_o,
    output logic [WAY_NUM-1:0]                        data_we_o,
    output logic [IDX_W-1:0]                          wr_index_o,
    output logic [PAIR_IDX_W-1:0]                     wr_pair_o,
    output logic [TAG_W-1:0]                          wr_tag_o,
    output logic [icache_cfg_pkg::PAIR_W-1:0]         wr_data_o,
    output logic                                      replay_o
);

    localparam int OFFSET_W = icache_cfg_pkg::OFFSET_W;
    localparam int CNT_W = $clog2(icache_cfg_pkg::LINE_WORDS);

    typedef enum logic [2:0] {S_IDLE, S_MISS_REQ, S_MISS_DATA, S_REPLAY, S_CACOP} state_t;

    state_t state_q;
    logic [ADDR_W-1:0] miss_pc_q;
    logic [CNT_W-1:0] word_cnt_q;
    logic [icache_cfg_pkg::INST_W-1:0] low_word_q;
    logic [SET_NUM-1:0] victim_q;
    logic [IDX_W-1:0] cacop_idx_q;
    logic drop_q;

    icache_op_pkg::cacop_addr_u caddr;
    assign caddr = cacop_addr_i;

    wire idle = (state_q == S_IDLE);
    wire cacop_fire = cacop_valid_i && cacop_ready_o;
    wire op_hit = (cacop_op_i == icache_op_pkg::CACOP_HIT_INV);
    wire op_index = (cacop_op_i == icache_op_pkg::CACOP_IDX_INIT)
                 || (cacop_op_i == icache_op_pkg::CACOP_IDX_INV);
    wire last_word = (word_cnt_q == CNT_W'(icache_cfg_pkg::LINE_WORDS - 1));

    // split of the held miss pc and of both cacop views
    wire [IDX_W-1:0] miss_idx = miss_pc_q[OFFSET_W +: IDX_W];
    wire [IDX_W-1:0] op_idx_index = caddr.index_view.upper[OFFSET_W-1 +: IDX_W];
    wire [IDX_W-1:0] op_idx_hit = caddr.hit_view.line_addr[IDX_W-1:0];
    wire [TAG_W-1:0] op_tag_hit = caddr.hit_view.line_addr[ADDR_W-OFFSET_W-1 -: TAG_W];
    wire [WAY_NUM-1:0] victim_way = WAY_NUM'(1) << victim_q[miss_idx];

    // cacop first, fetch waits for any pending miss
    assign cacop_ready_o = idle && !miss_i;
    assign fetch_ready_o = idle && !miss_i && !cacop_valid_i;

    assign mem_req_o = (state_q == S_MISS_REQ);
    assign mem_addr_o = {miss_pc_q[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
    assign mem_len_o = icache_cfg_pkg::BUS_LEN_W'(icache_cfg_pkg::LINE_WORDS);

    // read port mux: replay pc, hit cacop address or fetch pc
    always_comb begin
        rd_en_o = fetch_valid_i && fetch_ready_o;
        rd_index_o = fetch_pc_i[OFFSET_W +: IDX_W];
        rd_pair_o = fetch_pc_i[OFFSET_W-1 -: PAIR_IDX_W];
        lookup_tag_o = fetch_pc_i[ADDR_W-1 -: TAG_W];
        replay_o = 1'b0;
        if (state_q == S_REPLAY) begin
            rd_en_o = !drop_q;
            replay_o = !drop_q;
            rd_index_o = miss_idx;
            rd_pair_o = miss_pc_q[OFFSET_W-1 -: PAIR_IDX_W];
            lookup_tag_o = miss_pc_q[ADDR_W-1 -: TAG_W];
        end else if (cacop_fire && op_hit) begin
            rd_en_o = 1'b1;
            rd_index_o = op_idx_hit;
            lookup_tag_o = op_tag_hit;
        end
    end

    // shared write bus
    always_comb begin
        tag_we_o = '0;
        data_we_o = '0;
        wr_valid_o = 1'b0;
        wr_index_o = miss_idx;
        wr_pair_o = word_cnt_q[CNT_W-1:1];
        wr_tag_o = miss_pc_q[ADDR_W-1 -: TAG_W];
        wr_data_o = {mem_data_i, low_word_q};
        case (state_q)
            S_IDLE: begin
                if (cacop_fire && op_index) begin
                    wr_index_o = op_idx_index;
                    tag_we_o = WAY_NUM'(1) << caddr.index_view.way_sel;
                end
            end
            S_MISS_DATA: begin
                // odd word completes a pair
                if (mem_data_valid_i && word_cnt_q[0]) begin
                    data_we_o = victim_way;
                    if (last_word) begin
                        tag_we_o = victim_way;
                        wr_valid_o = 1'b1;
                    end
                end
            end
            S_CACOP: begin
                wr_index_o = cacop_idx_q;
                tag_we_o = way_hit_i;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            word_cnt_q <= '0;
            victim_q <= '0;
            drop_q <= 1'b0;
            cacop_done_o <= 1'b0;
        end else begin
            cacop_done_o <= (cacop_fire && !op_hit) || (state_q == S_CACOP);
            case (state_q)
                S_IDLE: begin
                    if (cacop_fire && op_hit) begin
                        state_q <= S_CACOP;
                    end else if (miss_i) begin
                        state_q <= S_MISS_REQ;
                        drop_q <= 1'b0;
                    end
                end
                S_MISS_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= S_MISS_DATA;
                        word_cnt_q <= '0;
                    end
                end
                S_MISS_DATA: begin
                    if (mem_data_valid_i) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            victim_q[miss_idx] <= !victim_q[miss_idx];
                            state_q <= S_REPLAY;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
            // flushed refill still fills the line but skips the replay
            if (flush_i && !idle) begin
                drop_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idle && miss_i) begin
            miss_pc_q <= miss_pc_i;
        end
        if (mem_data_valid_i && !word_cnt_q[0]) begin
            low_word_q <= mem_data_i;
        end
        if (cacop_fire) begin
            cacop_idx_q <= op_idx_hit;
        end
    end

endmodule

`default_nettype wire

//--- src/icache_hit_select.sv
`timescale 1ns/10ps
`default_nettype none

module icache_hit_select #(
    parameter int SET_NUM = 64,
    localparam int ADDR_W = icache_cfg_pkg::ADDR_W,
    localparam int PAIR_W = icache_cfg_pkg::PAIR_W,
    localparam int WAY_NUM = icache_cfg_pkg::WAY_NUM
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           flush_i,
    input  wire logic                           accept_i,
    input  wire logic [ADDR_W-1:0]              pc_i,
    input  wire logic [WAY_NUM-1:0]             way_hit_i,
    input  wire logic [WAY_NUM-1:0][PAIR_W-1:0] way_pair_i,
    output logic                                inst_valid_o,
    output logic [ADDR_W-1:0]                   inst_pc_o,
    output logic [PAIR_W-1:0]                   inst_pair_o,
    output logic                                miss_o,
    output logic [ADDR_W-1:0]                   miss_pc_o
);

    // set count outside the supported range stops elaboration
    if (SET_NUM < 16 || SET_NUM > 128 || (SET_NUM & (SET_NUM - 1)) != 0) begin : g_bad_sets
        $error("icache_hit_select: SET_NUM must be a power of two from 16 to 128");
    end

    logic s1_valid_q;
    logic [ADDR_W-1:0] s1_pc_q;
    logic miss_q;
    logic [ADDR_W-1:0] miss_pc_q;
    logic [PAIR_W-1:0] hit_pair;

    wire any_hit = |way_hit_i;
    wire s1_miss = s1_valid_q && !any_hit;

    always_comb begin
        hit_pair = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (way_hit_i[w]) begin
                hit_pair = way_pair_i[w];
            end
        end
    end

    // a flushed lookup must not start a refill
    assign miss_o = (s1_miss && !flush_i) || miss_q;
    assign miss_pc_o = miss_q ? miss_pc_q : s1_pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            s1_valid_q <= 1'b0;
            miss_q <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            s1_valid_q <= accept_i;
            inst_valid_o <= s1_valid_q && any_hit;
            if (accept_i) begin
                miss_q <= 1'b0;
            end else if (s1_miss) begin
                miss_q <= 1'b1;
            end
        end
    end

    // while a miss is held the only accept is its replay
    always_ff @(posedge clk) begin
        if (accept_i) begin
            s1_pc_q <= miss_q ? miss_pc_q : pc_i;
        end
        if (s1_miss) begin
            miss_pc_q <= s1_pc_q;
        end
        if (s1_valid_q) begin
            inst_pc_o <= s1_pc_q;
            inst_pair_o <= hit_pair;
        end
    end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
    parameter int SET_NUM = 64,
    localparam int IDX_W = $clog2(SET_NUM),
    localparam int TAG_W = icache_cfg_pkg::ADDR_W - icache_cfg_pkg::OFFSET_W - IDX_W,
    localparam int PAIR_IDX_W = $clog2(icache_cfg_pkg::LINE_PAIRS),
    localparam int ADDR_W = icache_cfg_pkg::ADDR_W,
    localparam int PAIR_W = icache_cfg_pkg::PAIR_W,
    localparam int WAY_NUM = icache_cfg_pkg::WAY_NUM
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              flush_i,
    input  wire logic                              fetch_valid_i,
    input  wire logic [ADDR_W-1:0]                 fetch_pc_i,
    output logic                                   fetch_ready_o,
    output logic                                   inst_valid_o,
    output logic [ADDR_W-1:0]                      inst_pc_o,
    output logic [PAIR_W-1:0]                      inst_pair_o,
    input  wire logic                              cacop_valid_i,
    input  wire logic [icache_op_pkg::OP_W-1:0]    cacop_op_i,
    input  wire logic [ADDR_W-1:0]                 cacop_addr_i,
    output logic                                   cacop_ready_o,
    output logic                                   cacop_done_o,
    output logic                                   mem_req_o,
    output logic [ADDR_W-1:0]                      mem_addr_o,
    output logic [icache_cfg_pkg::BUS_LEN_W-1:0]   mem_len_o,
    input  wire logic                              mem_ack_i,
    input  wire logic                              mem_data_valid_i,
    input  wire logic [icache_cfg_pkg::INST_W-1:0] mem_data_i
);

    logic rd_en;
    logic [IDX_W-1:0] rd_index;
    logic [PAIR_IDX_W-1:0] rd_pair;
    logic [TAG_W-1:0] lookup_tag;
    logic [WAY_NUM-1:0] tag_we;
    logic [WAY_NUM-1:0] data_we;
    logic wr_valid;
    logic [IDX_W-1:0] wr_index;
    logic [PAIR_IDX_W-1:0] wr_pair;
    logic [TAG_W-1:0] wr_tag;
    logic [PAIR_W-1:0] wr_data;
    logic [WAY_NUM-1:0] way_hit;
    logic [WAY_NUM-1:0][PAIR_W-1:0] way_pair;
    logic miss;
    logic [ADDR_W-1:0] miss_pc;
    logic replay;

    // a fetch or a replay enters the result stage
    wire accept = (fetch_valid_i && fetch_ready_o) || replay;

    icache_ctrl #(.SET_NUM(SET_NUM)) u_ctrl (
        .clk, .rst_n, .flush_i,
        .fetch_valid_i, .fetch_pc_i, .cacop_valid_i, .cacop_op_i, .cacop_addr_i,
        .mem_ack_i, .mem_data_valid_i, .mem_data_i,
        .miss_i(miss), .miss_pc_i(miss_pc), .way_hit_i(way_hit),
        .fetch_ready_o, .cacop_ready_o, .cacop_done_o,
        .mem_req_o, .mem_addr_o, .mem_len_o,
        .rd_en_o(rd_en), .rd_index_o(rd_index), .rd_pair_o(rd_pair),
        .lookup_tag_o(lookup_tag), .tag_we_o(tag_we), .wr_valid_o(wr_valid),
        .data_we_o(data_we), .wr_index_o(wr_index), .wr_pair_o(wr_pair),
        .wr_tag_o(wr_tag), .wr_data_o(wr_data), .replay_o(replay)
    );

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        icache_way #(.SET_NUM(SET_NUM)) u_way (
            .clk, .rst_n,
            .rd_en_i(rd_en), .rd_index_i(rd_index), .rd_pair_i(rd_pair),
            .lookup_tag_i(lookup_tag), .tag_we_i(tag_we[w]), .wr_valid_i(wr_valid),
            .data_we_i(data_we[w]), .wr_index_i(wr_index), .wr_pair_i(wr_pair),
            .wr_tag_i(wr_tag), .wr_data_i(wr_data),
            .hit_o(way_hit[w]), .pair_o(way_pair[w])
        );
    end

    icache_hit_select #(.SET_NUM(SET_NUM)) u_hit_select (
        .clk, .rst_n, .flush_i,
        .accept_i(accept), .pc_i(fetch_pc_i),
        .way_hit_i(way_hit), .way_pair_i(way_pair),
        .inst_valid_o, .inst_pc_o, .inst_pair_o,
        .miss_o(miss), .miss_pc_o(miss_pc)
    );

endmodule

`default_nettype wire

//--- testbench/icache_properties.sv
`timescale 1ns/10ps
`default_nettype none

module icache_properties (
    input wire logic                                 clk,
    input wire logic                                 rst_n,
    input wire logic                                 mem_req_o,
    input wire logic [icache_cfg_pkg::ADDR_W-1:0]    mem_addr_o,
    input wire logic                                 mem_ack_i,
    input wire logic                                 mem_data_valid_i,
    input wire logic                                 fetch_ready_o,
    input wire logic                                 cacop_ready_o
);

    // words still owed by the bus after an accepted request
    logic [3:0] words_left_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            words_left_q <= 4'd0;
        end else if (mem_req_o && mem_ack_i) begin
            words_left_q <= 4'd8;
        end else if (mem_data_valid_i && words_left_q != 4'd0) begin
            words_left_q <= words_left_q - 4'd1;
        end
    end

    wire refill_busy = mem_req_o || (words_left_q != 4'd0);

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("memory request dropped or changed before its ack");

    ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        refill_busy |-> !fetch_ready_o && !cacop_ready_o)
        else $error("fetch or cacop port ready during a refill");

endmodule

bind icache_top icache_properties u_properties (
    .clk, .rst_n, .mem_req_o, .mem_addr_o, .mem_ack_i,
    .mem_data_valid_i, .fetch_ready_o, .cacop_ready_o
);

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

    localparam int SETS = 16;
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_LSB = 5 + IDX_W;
    localparam int NUM_OPS = 24;
    localparam int REFILL_CYCLES = 60;
    localparam int TIMEOUT = NUM_OPS * REFILL_CYCLES;

    logic clk;
    logic rst_n;
    logic flush;
    logic fetch_valid;
    logic [31:0] fetch_pc;
    logic fetch_ready;
    logic inst_valid;
    logic [31:0] inst_pc;
    logic [63:0] inst_pair;
    logic cacop_valid;
    logic [1:0] cacop_op;
    logic [31:0] cacop_addr;
    logic cacop_ready;
    logic cacop_done;
    logic mem_req;
    logic [31:0] mem_addr;
    logic [3:0] mem_len;
    logic mem_ack;
    logic mem_dv;
    logic [31:0] mem_data;

    // reference model state
    logic [31:0] tag_m [2][SETS];
    logic valid_m [2][SETS];
    logic victim_m [SETS];

    // outstanding fetches and predicted bus requests
    logic [31:0] exp_pc [$];
    int exp_cycle [$];
    logic exp_hit [$];
    logic [31:0] req_q [$];

    logic [31:0] lfsr_q = 32'h2144;
    logic mem_busy = 1'b0;
    int cycle_cnt = 0;
    string test_name = "reset";

    icache_top #(.SET_NUM(SETS)) UUT (
        .clk(clk), .rst_n(rst_n), .flush_i(flush),
        .fetch_valid_i(fetch_valid), .fetch_pc_i(fetch_pc), .fetch_ready_o(fetch_ready),
        .inst_valid_o(inst_valid), .inst_pc_o(inst_pc), .inst_pair_o(inst_pair),
        .cacop_valid_i(cacop_valid), .cacop_op_i(cacop_op), .cacop_addr_i(cacop_addr),
        .cacop_ready_o(cacop_ready), .cacop_done_o(cacop_done),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_len_o(mem_len),
        .mem_ack_i(mem_ack), .mem_data_valid_i(mem_dv), .mem_data_i(mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory content, every address bit matters
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        return (addr * 32'h0019_660D) ^ 32'hA5A5_3C3C;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_failure(input string why);
        $display("error in %s: %s", test_name, why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    // lookup, and on a miss fill the victim way and toggle the victim bit
    task automatic model_fetch(input logic [31:0] pc, output logic hit);
        int idx;
        int way;
        logic [31:0] tag;
        idx = int'((pc >> 5) % SETS);
        tag = pc >> TAG_LSB;
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (valid_m[w][idx] && tag_m[w][idx] == tag) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            way = int'(victim_m[idx]);
            tag_m[way][idx] = tag;
            valid_m[way][idx] = 1'b1;
            victim_m[idx] = !victim_m[idx];
        end
    endtask

    task automatic model_cacop(input logic [1:0] op, input logic [31:0] addr);
        int idx;
        idx = int'((addr >> 5) % SETS);
        if (op == icache_op_pkg::CACOP_HIT_INV) begin
            for (int w = 0; w < 2; w++) begin
                if (valid_m[w][idx] && tag_m[w][idx] == (addr >> TAG_LSB)) begin
                    valid_m[w][idx] = 1'b0;
                end
            end
        end else begin
            valid_m[int'(addr[0])][idx] = 1'b0;
        end
    endtask

    // returns before the accepting edge, fetch_valid stays high
    task automatic issue_fetch(input logic [31:0] pc);
        logic hit;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_pc = pc;
        #1;
        while (!fetch_ready) begin
            @(negedge clk);
            #1;
        end
        model_fetch(pc, hit);
        exp_pc.push_back(pc);
        exp_cycle.push_back(cycle_cnt + 1);
        exp_hit.push_back(hit);
        if (!hit) begin
            req_q.push_back({pc[31:5], 5'd0});
        end
    endtask

    task automatic end_fetch();
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
            #1;
        end while (exp_pc.size() != 0 || req_q.size() != 0 || mem_busy || !cacop_ready);
    endtask

    task automatic fetch_single(input logic [31:0] pc);
        issue_fetch(pc);
        end_fetch();
        wait_idle();
    endtask

    task automatic run_cacop(input logic [1:0] op, input logic [31:0] addr);
        @(negedge clk);
        cacop_valid = 1'b1;
        cacop_op = op;
        cacop_addr = addr;
        #1;
        while (!cacop_ready) begin
            @(negedge clk);
            #1;
        end
        model_cacop(op, addr);
        @(negedge clk);
        cacop_valid = 1'b0;
        // hit invalidate needs one more cycle for its lookup
        if (op == icache_op_pkg::CACOP_HIT_INV) begin
            assert (!cacop_done) else report_mismatch("early cacop_done_o", 64'(0), 64'(1));
            @(negedge clk);
        end
        assert (cacop_done) else report_mismatch("cacop_done_o", 64'(1), 64'(0));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(negedge clk) begin
        if (cycle_cnt > TIMEOUT) begin
            report_failure($sformatf("no completion within %0d cycles", TIMEOUT));
        end
    end

    always @(negedge clk) begin : compare_outputs
        logic [31:0] pc;
        int acc;
        logic hit;
        if (rst_n && inst_valid) begin
            if (exp_pc.size() == 0) begin
                report_failure("inst_valid_o strobed with no fetch outstanding");
            end else begin
                pc = exp_pc.pop_front();
                acc = exp_cycle.pop_front();
                hit = exp_hit.pop_front();
                assert (inst_pc == pc) else report_mismatch("inst_pc_o", 64'(pc), 64'(inst_pc));
                assert (inst_pair == {ref_word(pc + 32'd4), ref_word(pc)})
                    else report_mismatch("inst_pair_o", {ref_word(pc + 32'd4), ref_word(pc)},
                                         inst_pair);
                if (hit) begin
                    assert (cycle_cnt == acc + 1)
                        else report_mismatch("hit latency", 64'(acc + 1), 64'(cycle_cnt));
                end
            end
        end
    end

    // bus slave with random ack delay and gaps between words
    initial begin : memory_model
        logic [31:0] addr;
        logic [31:0] r;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                if (req_q.size() == 0) begin
                    report_failure("bus request made although no miss was predicted");
                end else begin
                    mem_busy = 1'b1;
                    addr = req_q.pop_front();
                    assert (mem_addr == addr)
                        else report_mismatch("mem_addr_o", 64'(addr), 64'(mem_addr));
                    // one line is a burst of eight words
                    assert (mem_len == 4'd8)
                        else report_mismatch("mem_len_o", 64'(8), 64'(mem_len));
                    draw_bits(2, r);
                    repeat (r) @(negedge clk);
                    mem_ack = 1'b1;
                    @(negedge clk);
                    mem_ack = 1'b0;
                    for (int i = 0; i < 8; i++) begin
                        draw_bits(1, r);
                        if (r != 32'd0) begin
                            @(negedge clk);
                        end
                        mem_dv = 1'b1;
                        mem_data = ref_word(addr + 32'(4 * i));
                        @(negedge clk);
                        mem_dv = 1'b0;
                    end
                    mem_busy = 1'b0;
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = 32'd0;
        cacop_valid = 1'b0;
        cacop_op = 2'd0;
        cacop_addr = 32'd0;
        mem_ack = 1'b0;
        mem_dv = 1'b0;
        mem_data = 32'd0;
        for (int s = 0; s < SETS; s++) begin
            victim_m[s] = 1'b0;
            valid_m[0][s] = 1'b0;
            valid_m[1][s] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "cold_miss";
        fetch_single(32'h0000_1238);

        test_name = "same_line_hits";
        issue_fetch(32'h0000_1220);
        issue_fetch(32'h0000_1228);
        issue_fetch(32'h0000_1230);
        issue_fetch(32'h0000_1238);
        end_fetch();
        wait_idle();

        // three lines of set 3
        test_name = "victim_toggle";
        fetch_single(32'h0000_4060);
        fetch_single(32'h0000_8060);
        fetch_single(32'h0000_C068);
        fetch_single(32'h0000_4068);
        fetch_single(32'h0000_C060);

        test_name = "cacop_invalidate";
        run_cacop(icache_op_pkg::CACOP_IDX_INIT, 32'h0000_C060);
        fetch_single(32'h0000_4060);
        fetch_single(32'h0000_C070);
        run_cacop(icache_op_pkg::CACOP_HIT_INV, 32'h0000_4078);
        fetch_single(32'h0000_C078);
        fetch_single(32'h0000_4070);
        run_cacop(icache_op_pkg::CACOP_IDX_INV, 32'h0000_4061);
        fetch_single(32'h0000_4060);

        test_name = "flush_refill";
        issue_fetch(32'h0000_2410);
        end_fetch();
        while (!mem_req) begin
            @(negedge clk);
        end
        flush = 1'b1;
        void'(exp_pc.pop_back());
        void'(exp_cycle.pop_back());
        void'(exp_hit.pop_back());
        @(negedge clk);
        flush = 1'b0;
        wait_idle();
        fetch_single(32'h0000_2418);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_top.f
src/icache_cfg_pkg.sv
src/icache_op_pkg.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_hit_select.sv
src/icache_top.sv
testbench/icache_properties.sv
testbench/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f icache_top.f --top-module icache_tb \
    -Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    exit 1
fi
